//--- Makefile
TOP := tb_wb_mem_sys
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): wb_mem_sys.f *.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f wb_mem_sys.f

# The log decides the outcome, since an assertion stop never prints the pass line
run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "Simulation did not pass"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

//--- bexkat_mem_pkg.sv
`default_nettype none

package bexkat_mem_pkg;

  // Wishbone bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // RAM depths in 32-bit words
  localparam int RAM0_WORDS = 1024;
  localparam int RAM1_WORDS = 256;

  // Word offset handed to the RAMs, sized for the larger one
  localparam int RAM_AW = 10;

  // The region is selected by the top address nibble
  localparam int REGION_W = 4;
  localparam logic [REGION_W-1:0] REGION_RAM0 = 4'h0;
  localparam logic [REGION_W-1:0] REGION_RAM1 = 4'h7;

  typedef enum logic [1:0] {
    REG_RAM0,
    REG_RAM1,
    REG_NONE
  } region_e;

  // Map a byte address onto its region
  function automatic region_e region_of(input logic [ADDR_W-1:0] adr);
    logic [REGION_W-1:0] nib;
    nib = adr[ADDR_W-1 -: REGION_W];
    case (nib)
      REGION_RAM0: return REG_RAM0;
      REGION_RAM1: return REG_RAM1;
      default:     return REG_NONE;
    endcase
  endfunction

  // Word offset inside a region, byte lane bits dropped
  function automatic logic [RAM_AW-1:0] word_offset(input logic [ADDR_W-1:0] adr);
    return adr[RAM_AW+1:2];
  endfunction

endpackage

`default_nettype wire

//--- tb_wb_mem_sys.sv
`default_nettype none

module tb_wb_mem_sys;
  timeunit 1ns;
  timeprecision 1ps;
  import bexkat_mem_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRV_DLY    = 2;
  localparam int RESP_LIMIT = 16;

  logic              clk;
  logic              rst_n;
  logic              ibus_cyc;
  logic              ibus_stb;
  logic [ADDR_W-1:0] ibus_adr;
  logic              ibus_ack;
  logic              ibus_err;
  logic [DATA_W-1:0] ibus_dat;
  logic              dbus_cyc;
  logic              dbus_stb;
  logic              dbus_we;
  logic [SEL_W-1:0]  dbus_sel;
  logic [ADDR_W-1:0] dbus_adr;
  logic [DATA_W-1:0] dbus_wdat;
  logic              dbus_ack;
  logic              dbus_err;
  logic [DATA_W-1:0] dbus_rdat;

  // Reference copies of the two RAMs
  logic [DATA_W-1:0] ref0 [RAM0_WORDS];
  logic [DATA_W-1:0] ref1 [RAM1_WORDS];
  int unsigned       errors;
  int unsigned       checks;
  int unsigned       tests_run;
  int unsigned       tests_failed;

  wb_mem_sys wb_mem_sys_inst (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .ibus_cyc_i (ibus_cyc),
    .ibus_stb_i (ibus_stb),
    .ibus_adr_i (ibus_adr),
    .ibus_ack_o (ibus_ack),
    .ibus_err_o (ibus_err),
    .ibus_dat_o (ibus_dat),
    .dbus_cyc_i (dbus_cyc),
    .dbus_stb_i (dbus_stb),
    .dbus_we_i  (dbus_we),
    .dbus_sel_i (dbus_sel),
    .dbus_adr_i (dbus_adr),
    .dbus_dat_i (dbus_wdat),
    .dbus_ack_o (dbus_ack),
    .dbus_err_o (dbus_err),
    .dbus_dat_o (dbus_rdat)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic bit unmapped(input logic [ADDR_W-1:0] adr);
    return adr[31:28] != REGION_RAM0 && adr[31:28] != REGION_RAM1;
  endfunction

  // Offset bits above a RAM's depth are dropped, so the slices alias
  function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] adr);
    if (adr[31:28] == REGION_RAM1) begin
      return ref1[adr[9:2]];
    end
    return ref0[adr[11:2]];
  endfunction

  function automatic void model_write(input logic [ADDR_W-1:0] adr,
                                      input logic [SEL_W-1:0] sel,
                                      input logic [DATA_W-1:0] dat);
    logic [DATA_W-1:0] word;
    word = model_read(adr);
    for (int i = 0; i < SEL_W; i++) begin
      if (sel[i]) begin
        word[i*8 +: 8] = dat[i*8 +: 8];
      end
    end
    if (adr[31:28] == REGION_RAM1) begin
      ref1[adr[9:2]] = word;
    end else begin
      ref0[adr[11:2]] = word;
    end
  endfunction

  function automatic logic [ADDR_W-1:0] rand_adr(input logic [3:0] nib);
    logic [9:0] word;
    word = 10'($urandom);
    if (nib == REGION_RAM1) begin
      word[9:8] = 2'b00;
    end
    return {nib, 16'h0, word, 2'b00};
  endfunction

  task automatic check_resp(input string port, input logic [ADDR_W-1:0] adr, input logic ack,
                            input logic err, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp, input bit is_read);
    checks++;
    if (unmapped(adr)) begin
      if (!err || ack) begin
        errors++;
        $display("Unmapped access to 0x%08h on %s was not answered by err alone", adr, port);
      end
    end else if (!ack || err) begin
      errors++;
      $display("Access to 0x%08h on %s was not answered by ack alone", adr, port);
    end else if (is_read && got !== exp) begin
      errors++;
      $display("FAIL %s_dat_o at 0x%08h: got 0x%08h, expected 0x%08h", port, adr, got, exp);
    end
  endtask

  task automatic wait_ibus(output logic ack, output logic err, output logic [DATA_W-1:0] got);
    int unsigned n;
    n   = 0;
    ack = 1'b0;
    err = 1'b0;
    got = '0;
    while (!ack && !err && n < RESP_LIMIT) begin
      @(negedge clk);
      ack = ibus_ack;
      err = ibus_err;
      got = ibus_dat;
      n++;
    end
    if (!ack && !err) begin
      $display("Timeout: instruction bus gave no ack or err within %0d cycles", RESP_LIMIT);
    end
  endtask

  task automatic wait_dbus(output logic ack, output logic err, output logic [DATA_W-1:0] got);
    int unsigned n;
    n   = 0;
    ack = 1'b0;
    err = 1'b0;
    got = '0;
    while (!ack && !err && n < RESP_LIMIT) begin
      @(negedge clk);
      ack = dbus_ack;
      err = dbus_err;
      got = dbus_rdat;
      n++;
    end
    if (!ack && !err) begin
      $display("Timeout: data bus gave no ack or err within %0d cycles", RESP_LIMIT);
    end
  endtask

  // Each bus task starts and ends just after a rising edge, with one idle cycle
  task automatic ibus_read(input logic [ADDR_W-1:0] adr);
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] got;
    logic [DATA_W-1:0] exp;
    exp      = model_read(adr);
    ibus_adr = adr;
    ibus_cyc = 1'b1;
    ibus_stb = 1'b1;
    wait_ibus(ack, err, got);
    @(posedge clk);
    #DRV_DLY;
    ibus_cyc = 1'b0;
    ibus_stb = 1'b0;
    @(posedge clk);
    #DRV_DLY;
    check_resp("ibus", adr, ack, err, got, exp, 1'b1);
  endtask

  task automatic dbus_access(input logic [ADDR_W-1:0] adr, input logic we,
                             input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] dat);
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] got;
    logic [DATA_W-1:0] exp;
    exp       = model_read(adr);
    dbus_adr  = adr;
    dbus_we   = we;
    dbus_sel  = sel;
    dbus_wdat = dat;
    dbus_cyc  = 1'b1;
    dbus_stb  = 1'b1;
    wait_dbus(ack, err, got);
    @(posedge clk);
    #DRV_DLY;
    dbus_cyc = 1'b0;
    dbus_stb = 1'b0;
    dbus_we  = 1'b0;
    @(posedge clk);
    #DRV_DLY;
    check_resp("dbus", adr, ack, err, got, exp, !we);
    if (we && !unmapped(adr)) begin
      model_write(adr, sel, dat);
    end
  endtask

  task automatic dbus_write(input logic [ADDR_W-1:0] adr, input logic [SEL_W-1:0] sel,
                            input logic [DATA_W-1:0] dat);
    dbus_access(adr, 1'b1, sel, dat);
  endtask

  task automatic dbus_read(input logic [ADDR_W-1:0] adr);
    dbus_access(adr, 1'b0, 4'hf, '0);
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  initial begin
    logic [ADDR_W-1:0] adr;
    logic [3:0]        nib;
    int unsigned       mark;
    void'($urandom(75882));
    rst_n     = 1'b0;
    ibus_cyc  = 1'b0;
    ibus_stb  = 1'b0;
    ibus_adr  = '0;
    dbus_cyc  = 1'b0;
    dbus_stb  = 1'b0;
    dbus_we   = 1'b0;
    dbus_sel  = '0;
    dbus_adr  = '0;
    dbus_wdat = '0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    #DRV_DLY;
    rst_n = 1'b1;
    @(posedge clk);
    #DRV_DLY;

    // Every word gets a value first so no later read sees an unwritten location
    mark = errors;
    for (int i = 0; i < RAM0_WORDS; i++) begin
      dbus_write({REGION_RAM0, 16'h0, 10'(i), 2'b00}, 4'hf, $urandom);
    end
    for (int i = 0; i < RAM1_WORDS; i++) begin
      dbus_write({REGION_RAM1, 18'h0, 8'(i), 2'b00}, 4'hf, $urandom);
    end
    for (int i = 0; i < 64; i++) begin
      nib = i[0] ? REGION_RAM1 : REGION_RAM0;
      adr = rand_adr(nib);
      dbus_write(adr, 4'hf, $urandom);
      dbus_read(adr);
    end
    finish_test("data port write and readback", mark);

    mark = errors;
    for (int i = 0; i < 32; i++) begin
      nib = i[0] ? REGION_RAM1 : REGION_RAM0;
      adr = rand_adr(nib);
      dbus_write(adr, 4'hf, $urandom);
      ibus_read(adr);
    end
    finish_test("instruction port reads data port writes", mark);

    mark = errors;
    for (int s = 1; s < 15; s++) begin
      nib = s[0] ? REGION_RAM1 : REGION_RAM0;
      adr = rand_adr(nib);
      dbus_write(adr, 4'(s), $urandom);
      dbus_read(adr);
      ibus_read(adr);
    end
    finish_test("partial byte select writes", mark);

    mark = errors;
    dbus_write(32'h3000_0010, 4'hf, 32'hdead_beef);
    dbus_read(32'h3000_0010);
    ibus_read(32'h3000_0010);
    ibus_read(32'hf000_0004);
    dbus_read(32'h0000_0010);
    dbus_read(32'h7000_0010);
    finish_test("unmapped regions answer with err", mark);

    mark = errors;
    fork
      ibus_read(32'h0000_0040);
      dbus_read(32'h0000_0080);
    join
    fork
      ibus_read(32'h7000_0040);
      dbus_write(32'h7000_0044, 4'hf, $urandom);
    join
    fork
      ibus_read(32'h7000_0010);
      dbus_write(32'h0000_0010, 4'hf, $urandom);
    join
    fork
      ibus_read(32'h0000_0020);
      dbus_read(32'h7000_0020);
    join
    // Same word on both ports, the instruction side must see the old value
    fork
      ibus_read(32'h0000_0100);
      dbus_write(32'h0000_0100, 4'hf, $urandom);
    join
    ibus_read(32'h0000_0100);
    finish_test("simultaneous instruction and data accesses", mark);

    mark = errors;
    dbus_write(32'h7000_0400, 4'hf, $urandom);
    dbus_read(32'h7000_0000);
    ibus_read(32'h7000_0000);
    dbus_write(32'h0000_1000, 4'hf, $urandom);
    dbus_read(32'h0000_0000);
    finish_test("offsets alias beyond RAM depth", mark);

    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- wb_dpram.sv
`default_nettype none

module wb_dpram #(
  parameter int DEPTH = bexkat_mem_pkg::RAM0_WORDS
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Port a, read only
  input  logic                                a_stb_i,
  input  logic [bexkat_mem_pkg::RAM_AW-1:0]   a_adr_i,
  output logic                                a_ack_o,
  output logic [bexkat_mem_pkg::DATA_W-1:0]   a_dat_o,
  // Port b, read and write
  input  logic                                b_stb_i,
  input  logic                                b_we_i,
  input  logic [bexkat_mem_pkg::SEL_W-1:0]    b_sel_i,
  input  logic [bexkat_mem_pkg::RAM_AW-1:0]   b_adr_i,
  input  logic [bexkat_mem_pkg::DATA_W-1:0]   b_dat_i,
  output logic                                b_ack_o,
  output logic [bexkat_mem_pkg::DATA_W-1:0]   b_dat_o
);
  import bexkat_mem_pkg::*;

  // DEPTH must be a power of two no larger than 2**RAM_AW
  localparam int IDX_W = $clog2(DEPTH);

  logic [DATA_W-1:0] mem [DEPTH];

  logic [IDX_W-1:0]  a_idx;
  logic [IDX_W-1:0]  b_idx;
  logic              a_req;
  logic              b_req;
  logic              a_ack_q;
  logic              b_ack_q;
  logic [DATA_W-1:0] a_dat_q;
  logic [DATA_W-1:0] b_dat_q;

  // High offset bits are dropped, so addresses wrap inside the RAM
  assign a_idx = a_adr_i[IDX_W-1:0];
  assign b_idx = b_adr_i[IDX_W-1:0];

  // A new access starts only while the previous ack is low
  assign a_req = a_stb_i & ~a_ack_q;
  assign b_req = b_stb_i & ~b_ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_ack_q <= 1'b0;
    end else begin
      a_ack_q <= a_req;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_ack_q <= 1'b0;
    end else begin
      b_ack_q <= b_req;
    end
  end

  // Port a reads the contents from before any write in the same cycle
  always_ff @(posedge clk_i) begin
    if (a_req) begin
      a_dat_q <= mem[a_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_req) begin
      b_dat_q <= mem[b_idx];
      if (b_we_i) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (b_sel_i[i]) begin
            mem[b_idx][i*8 +: 8] <= b_dat_i[i*8 +: 8];
          end
        end
      end
    end
  end

  assign a_ack_o = a_ack_q;
  assign a_dat_o = a_dat_q;
  assign b_ack_o = b_ack_q;
  assign b_dat_o = b_dat_q;

endmodule

`default_nettype wire

//--- wb_mem_sys.f
bexkat_mem_pkg.sv
wb_mmu.sv
wb_dpram.sv
wb_mem_sys.sv
wb_mem_sys_asserts.sv
tb_wb_mem_sys.sv

//--- wb_mem_sys.sv
`default_nettype none

module wb_mem_sys (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Instruction bus, read only
  input  logic                                ibus_cyc_i,
  input  logic                                ibus_stb_i,
  input  logic [bexkat_mem_pkg::ADDR_W-1:0]   ibus_adr_i,
  output logic                                ibus_ack_o,
  output logic                                ibus_err_o,
  output logic [bexkat_mem_pkg::DATA_W-1:0]   ibus_dat_o,
  // Data bus
  input  logic                                dbus_cyc_i,
  input  logic                                dbus_stb_i,
  input  logic                                dbus_we_i,
  input  logic [bexkat_mem_pkg::SEL_W-1:0]    dbus_sel_i,
  input  logic [bexkat_mem_pkg::ADDR_W-1:0]   dbus_adr_i,
  input  logic [bexkat_mem_pkg::DATA_W-1:0]   dbus_dat_i,
  output logic                                dbus_ack_o,
  output logic                                dbus_err_o,
  output logic [bexkat_mem_pkg::DATA_W-1:0]   dbus_dat_o
);
  import bexkat_mem_pkg::*;

  // Instruction side lands on port a of each RAM
  logic              ram0_a_stb;
  logic [RAM_AW-1:0] ram0_a_adr;
  logic              ram0_a_ack;
  logic [DATA_W-1:0] ram0_a_dat;
  logic              ram1_a_stb;
  logic [RAM_AW-1:0] ram1_a_adr;
  logic              ram1_a_ack;
  logic [DATA_W-1:0] ram1_a_dat;

  // Data side lands on port b
  logic              ram0_b_stb;
  logic              ram0_b_we;
  logic [SEL_W-1:0]  ram0_b_sel;
  logic [RAM_AW-1:0] ram0_b_adr;
  logic [DATA_W-1:0] ram0_b_wdat;
  logic              ram0_b_ack;
  logic [DATA_W-1:0] ram0_b_rdat;
  logic              ram1_b_stb;
  logic              ram1_b_we;
  logic [SEL_W-1:0]  ram1_b_sel;
  logic [RAM_AW-1:0] ram1_b_adr;
  logic [DATA_W-1:0] ram1_b_wdat;
  logic              ram1_b_ack;
  logic [DATA_W-1:0] ram1_b_rdat;

  wb_mmu ibus_mmu (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cyc_i    (ibus_cyc_i),
    .stb_i    (ibus_stb_i),
    .we_i     (1'b0),
    .sel_i    ('1),
    .adr_i    (ibus_adr_i),
    .dat_i    ('0),
    .ack_o    (ibus_ack_o),
    .err_o    (ibus_err_o),
    .dat_o    (ibus_dat_o),
    .r0_stb_o (ram0_a_stb),
    .r0_we_o  (),
    .r0_sel_o (),
    .r0_adr_o (ram0_a_adr),
    .r0_dat_o (),
    .r0_ack_i (ram0_a_ack),
    .r0_dat_i (ram0_a_dat),
    .r1_stb_o (ram1_a_stb),
    .r1_we_o  (),
    .r1_sel_o (),
    .r1_adr_o (ram1_a_adr),
    .r1_dat_o (),
    .r1_ack_i (ram1_a_ack),
    .r1_dat_i (ram1_a_dat)
  );

  wb_mmu dbus_mmu (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .cyc_i    (dbus_cyc_i),
    .stb_i    (dbus_stb_i),
    .we_i     (dbus_we_i),
    .sel_i    (dbus_sel_i),
    .adr_i    (dbus_adr_i),
    .dat_i    (dbus_dat_i),
    .ack_o    (dbus_ack_o),
    .err_o    (dbus_err_o),
    .dat_o    (dbus_dat_o),
    .r0_stb_o (ram0_b_stb),
    .r0_we_o  (ram0_b_we),
    .r0_sel_o (ram0_b_sel),
    .r0_adr_o (ram0_b_adr),
    .r0_dat_o (ram0_b_wdat),
    .r0_ack_i (ram0_b_ack),
    .r0_dat_i (ram0_b_rdat),
    .r1_stb_o (ram1_b_stb),
    .r1_we_o  (ram1_b_we),
    .r1_sel_o (ram1_b_sel),
    .r1_adr_o (ram1_b_adr),
    .r1_dat_o (ram1_b_wdat),
    .r1_ack_i (ram1_b_ack),
    .r1_dat_i (ram1_b_rdat)
  );

  wb_dpram #(
    .DEPTH (RAM0_WORDS)
  ) ram0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .a_stb_i (ram0_a_stb),
    .a_adr_i (ram0_a_adr),
    .a_ack_o (ram0_a_ack),
    .a_dat_o (ram0_a_dat),
    .b_stb_i (ram0_b_stb),
    .b_we_i  (ram0_b_we),
    .b_sel_i (ram0_b_sel),
    .b_adr_i (ram0_b_adr),
    .b_dat_i (ram0_b_wdat),
    .b_ack_o (ram0_b_ack),
    .b_dat_o (ram0_b_rdat)
  );

  wb_dpram #(
    .DEPTH (RAM1_WORDS)
  ) ram1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .a_stb_i (ram1_a_stb),
    .a_adr_i (ram1_a_adr),
    .a_ack_o (ram1_a_ack),
    .a_dat_o (ram1_a_dat),
    .b_stb_i (ram1_b_stb),
    .b_we_i  (ram1_b_we),
    .b_sel_i (ram1_b_sel),
    .b_adr_i (ram1_b_adr),
    .b_dat_i (ram1_b_wdat),
    .b_ack_o (ram1_b_ack),
    .b_dat_o (ram1_b_rdat)
  );

endmodule

`default_nettype wire

//--- wb_mem_sys_asserts.sv
`default_nettype none

module wb_mem_sys_asserts (
  input logic                                clk_i,
  input logic                                rst_n_i,
  input logic                                ibus_cyc_i,
  input logic                                ibus_stb_i,
  input logic [bexkat_mem_pkg::ADDR_W-1:0]   ibus_adr_i,
  input logic                                ibus_ack_i,
  input logic                                ibus_err_i,
  input logic [bexkat_mem_pkg::DATA_W-1:0]   ibus_dat_i,
  input logic                                dbus_cyc_i,
  input logic                                dbus_stb_i,
  input logic                                dbus_we_i,
  input logic [bexkat_mem_pkg::ADDR_W-1:0]   dbus_adr_i,
  input logic                                dbus_ack_i,
  input logic                                dbus_err_i,
  input logic [bexkat_mem_pkg::DATA_W-1:0]   dbus_dat_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import bexkat_mem_pkg::*;

  logic    ibus_new;
  logic    dbus_new;
  region_e ibus_region;
  region_e dbus_region;

  // A new request is one that has not been answered yet
  assign ibus_new = ibus_cyc_i & ibus_stb_i & ~ibus_ack_i & ~ibus_err_i;
  assign dbus_new = dbus_cyc_i & dbus_stb_i & ~dbus_ack_i & ~dbus_err_i;

  assign ibus_region = (ibus_adr_i[ADDR_W-1 -: 4] == REGION_RAM0) ? REG_RAM0 :
                       (ibus_adr_i[ADDR_W-1 -: 4] == REGION_RAM1) ? REG_RAM1 : REG_NONE;
  assign dbus_region = (dbus_adr_i[ADDR_W-1 -: 4] == REGION_RAM0) ? REG_RAM0 :
                       (dbus_adr_i[ADDR_W-1 -: 4] == REGION_RAM1) ? REG_RAM1 : REG_NONE;

  a_ibus_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ibus_ack_i && ibus_err_i)) else $error("ibus ack and err high together");
  a_dbus_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dbus_ack_i && dbus_err_i)) else $error("dbus ack and err high together");

  a_ibus_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibus_new |=> (ibus_ack_i || ibus_err_i)) else $error("ibus request not answered in one cycle");
  a_dbus_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dbus_new |=> (dbus_ack_i || dbus_err_i)) else $error("dbus request not answered in one cycle");

  // Unmapped regions must only ever see err
  a_ibus_unmapped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibus_new && ibus_region == REG_NONE |=> ibus_err_i && !ibus_ack_i)
    else $error("ibus unmapped access not answered by err");
  a_dbus_unmapped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dbus_new && dbus_region == REG_NONE |=> dbus_err_i && !dbus_ack_i)
    else $error("dbus unmapped access not answered by err");

  a_ibus_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ibus_ack_i || ibus_err_i) |-> $past(ibus_cyc_i && ibus_stb_i))
    else $error("ibus response without a request");
  a_dbus_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dbus_ack_i || dbus_err_i) |-> $past(dbus_cyc_i && dbus_stb_i))
    else $error("dbus response without a request");

  // Write cycles return don't-care data, so only reads are checked
  a_ibus_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibus_ack_i |-> !$isunknown(ibus_dat_i)) else $error("ibus read data unknown at ack");
  a_dbus_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dbus_ack_i && !dbus_we_i |-> !$isunknown(dbus_dat_i))
    else $error("dbus read data unknown at ack");

endmodule

bind wb_mem_sys wb_mem_sys_asserts asserts_inst (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .ibus_cyc_i (ibus_cyc_i),
  .ibus_stb_i (ibus_stb_i),
  .ibus_adr_i (ibus_adr_i),
  .ibus_ack_i (ibus_ack_o),
  .ibus_err_i (ibus_err_o),
  .ibus_dat_i (ibus_dat_o),
  .dbus_cyc_i (dbus_cyc_i),
  .dbus_stb_i (dbus_stb_i),
  .dbus_we_i  (dbus_we_i),
  .dbus_adr_i (dbus_adr_i),
  .dbus_ack_i (dbus_ack_o),
  .dbus_err_i (dbus_err_o),
  .dbus_dat_i (dbus_dat_o)
);

`default_nettype wire

//--- wb_mmu.sv
`default_nettype none

module wb_mmu (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Master side
  input  logic                                cyc_i,
  input  logic                                stb_i,
  input  logic                                we_i,
  input  logic [bexkat_mem_pkg::SEL_W-1:0]    sel_i,
  input  logic [bexkat_mem_pkg::ADDR_W-1:0]   adr_i,
  input  logic [bexkat_mem_pkg::DATA_W-1:0]   dat_i,
  output logic                                ack_o,
  output logic                                err_o,
  output logic [bexkat_mem_pkg::DATA_W-1:0]   dat_o,
  // Region 0 RAM port
  output logic                                r0_stb_o,
  output logic                                r0_we_o,
  output logic [bexkat_mem_pkg::SEL_W-1:0]    r0_sel_o,
  output logic [bexkat_mem_pkg::RAM_AW-1:0]   r0_adr_o,
  output logic [bexkat_mem_pkg::DATA_W-1:0]   r0_dat_o,
  input  logic                                r0_ack_i,
  input  logic [bexkat_mem_pkg::DATA_W-1:0]   r0_dat_i,
  // Region 7 RAM port
  output logic                                r1_stb_o,
  output logic                                r1_we_o,
  output logic [bexkat_mem_pkg::SEL_W-1:0]    r1_sel_o,
  output logic [bexkat_mem_pkg::RAM_AW-1:0]   r1_adr_o,
  output logic [bexkat_mem_pkg::DATA_W-1:0]   r1_dat_o,
  input  logic                                r1_ack_i,
  input  logic [bexkat_mem_pkg::DATA_W-1:0]   r1_dat_i
);
  import bexkat_mem_pkg::*;

  region_e             region;
  logic                req;
  logic [RAM_AW-1:0]   offset;
  logic                err_q;

  assign region = region_of(adr_i);
  assign offset = word_offset(adr_i);
  assign req    = cyc_i & stb_i;

  // Only the selected RAM sees the strobe, the rest of the request fans out to both
  assign r0_stb_o = req & (region == REG_RAM0);
  assign r0_we_o  = we_i;
  assign r0_sel_o = sel_i;
  assign r0_adr_o = offset;
  assign r0_dat_o = dat_i;

  assign r1_stb_o = req & (region == REG_RAM1);
  assign r1_we_o  = we_i;
  assign r1_sel_o = sel_i;
  assign r1_adr_o = offset;
  assign r1_dat_o = dat_i;

  // Unmapped accesses are answered here with the same latency as a RAM ack
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req & (region == REG_NONE) & ~err_q;
    end
  end

  assign err_o = err_q;

  // The master holds its address until the response, so the decode still selects
  // the RAM that owns the pending request
  always_comb begin
    ack_o = 1'b0;
    dat_o = '0;
    case (region)
      REG_RAM0: begin
        ack_o = cyc_i & r0_ack_i;
        dat_o = r0_dat_i;
      end
      REG_RAM1: begin
        ack_o = cyc_i & r1_ack_i;
        dat_o = r1_dat_i;
      end
      default: begin
        ack_o = 1'b0;
        dat_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire
